// ==== project.f ====
echo_pkg.sv
uart_rx.sv
ping_sequencer.sv
first_echo_timer.sv
last_echo_timer.sv
range_accumulator.sv
echo_ranger.sv
tb_echo_ranger.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_echo_ranger -f project.f -o tb_echo_ranger \
    && ./obj_dir/tb_echo_ranger | tee /dev/stderr \
        | grep -q "Simulation completed successfully" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// ==== tb_echo_ranger.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_echo_ranger;

    localparam int RUN_CYCLES = echo_pkg::PINGS_PER_RUN * echo_pkg::PING_PERIOD;
    localparam int CMD_DELAY  = echo_pkg::CLKS_PER_BIT / 2 + 9 * echo_pkg::CLKS_PER_BIT + 1;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          rx_serial;
    logic                          echo_stb;
    logic                          ping_stb;
    logic [echo_pkg::RESULT_W-1:0] range;
    logic                          range_stb;
    logic                          frame_err;

    integer seed      = 32'hf2c1_027f;
    int     errors    = 0;
    int     range_cnt = 0;
    int     cyc       = 0;
    int     echo_mode = 0;  // 0 none, 1 random, 2 time 1 only, 3 ping cycle and last slot
    logic   next_rx   = 1'b1;
    logic   cmd_arm   = 1'b0;
    logic   cmd_good  = 1'b0;
    int     cmd_cd    = 0;  // cycles until the receiver ends the byte in flight

    // reference model
    logic                             m_running = 1'b0;
    logic                             m_first   = 1'b0;
    logic [echo_pkg::RUN_W-1:0]       m_cnt     = '0;
    logic                             w_hit     = 1'b0;
    int                               w_first   = 0;
    int                               w_last    = 0;
    int                               sum_first = 0;
    int                               sum_last  = 0;
    logic                             exp_rstb  = 1'b0;
    int                               exp_range = 0;
    int                               run_start = 0;
    int                               closing_start = 0;
    int                               run_pings = 0;  // pings seen since the run began
    logic [echo_pkg::PING_PERIOD-1:0] echo_mask = '0;
    logic                             coin      = 1'b0;

    always #50 clk = ~clk;

    echo_ranger DUT (
        .clk       (clk),
        .rst       (rst),
        .rx_serial (rx_serial),
        .echo_stb  (echo_stb),
        .ping_stb  (ping_stb),
        .range     (range),
        .range_stb (range_stb),
        .frame_err (frame_err)
    );

    // ####################################################################
    // one clock cycle of checks, model update and stimulus
    // ####################################################################

    task automatic cycle();
        logic [echo_pkg::WIN_W-1:0] pos;
        logic                       cmd_now;
        logic                       exp_ping;
        logic                       exp_run;
        logic                       echo;
        int                         n;
        @(posedge clk);
        #1;
        cyc++;
        cmd_now = 1'b0;
        if (cmd_cd > 0) begin
            cmd_cd--;
            cmd_now = (cmd_cd == 0);
        end
        pos      = m_cnt[echo_pkg::WIN_W-1:0];
        exp_ping = m_running && (pos == '0);
        exp_run  = exp_ping && (m_cnt == '0) && !m_first;
        if (ping_stb !== exp_ping) begin
            errors++;
            $display("Fail ping_stb: got %h expected %h (cycle %0d)", ping_stb, exp_ping, cyc);
        end
        if (frame_err !== (cmd_now && !cmd_good)) begin
            errors++;
            $display("Fail frame_err: got %h expected %h (cycle %0d)", frame_err,
                     cmd_now && !cmd_good, cyc);
        end
        if (range_stb !== exp_rstb) begin
            errors++;
            $display("Fail range_stb: got %h expected %h (cycle %0d)", range_stb, exp_rstb, cyc);
        end else if (range_stb) begin
            if (range !== echo_pkg::RESULT_W'(exp_range)) begin
                errors++;
                $display("Fail range: got %h expected %h", range, echo_pkg::RESULT_W'(exp_range));
            end
        end
        if (range_stb === 1'b1) begin
            range_cnt++;
            if (cyc - closing_start != RUN_CYCLES + 1) begin
                errors++;
                $display("range_stb came %0d cycles after the first ping of its run",
                         cyc - closing_start);
            end
        end
        // runs are timed from the pings the DUT actually sends
        if (ping_stb === 1'b1) begin
            if (run_pings == echo_pkg::PINGS_PER_RUN) begin
                closing_start = run_start;
                run_pings     = 0;
            end
            if (run_pings == 0) begin
                run_start = cyc;
            end
            run_pings++;
        end
        // the window that ends at this ping is folded before it is cleared
        if (exp_ping) begin
            if (w_hit) begin
                sum_first += w_first;
                sum_last  += w_last;
            end
            if (exp_run) begin
                exp_range = (sum_first >> echo_pkg::SUM_SHIFT) + (sum_last >> echo_pkg::SUM_SHIFT);
                sum_first = 0;
                sum_last  = 0;
            end
            w_hit     = 1'b0;
            echo_mask = '0;
            n         = {$random(seed)} % 5;
            repeat (n) echo_mask[echo_pkg::WIN_W'($random(seed))] = 1'b1;
            coin = 1'($random(seed));
        end
        case (echo_mode)
            1: echo = m_running ? echo_mask[pos] : (4'($random(seed)) == 4'd0);
            2: echo = m_running && coin && (pos == 1);
            3: echo = m_running && (pos == '0 || pos == '1);
            default: echo = 1'b0;
        endcase
        if (echo && m_running && !exp_ping && !(cmd_now && cmd_good)) begin
            if (!w_hit) begin
                w_first = int'(pos);
            end
            w_hit  = 1'b1;
            w_last = int'(pos);
        end
        exp_rstb = exp_run && !(cmd_now && cmd_good);
        if (cmd_now && cmd_good) begin  // a good byte restarts the whole run
            m_running = 1'b1;
            m_first   = 1'b1;
            m_cnt     = '0;
            sum_first = 0;
            sum_last  = 0;
            w_hit     = 1'b0;
            run_pings = 0;
        end else if (m_running) begin
            if (exp_ping) begin
                m_first = 1'b0;
            end
            m_cnt = m_cnt + 1'b1;
        end
        echo_stb  = echo;
        rx_serial = next_rx;
        if (cmd_arm) begin
            cmd_cd  = CMD_DELAY;
            cmd_arm = 1'b0;
        end
    endtask

    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        cmd_good = stop_bit;
        cmd_arm  = 1'b1;
        next_rx  = 1'b0;
        repeat (echo_pkg::CLKS_PER_BIT) cycle();
        for (int i = 0; i < 8; i++) begin
            next_rx = data[i];  // lsb first
            repeat (echo_pkg::CLKS_PER_BIT) cycle();
        end
        next_rx = stop_bit;
        repeat (echo_pkg::CLKS_PER_BIT) cycle();
        next_rx = 1'b1;
    endtask

    task automatic wait_ranges(input int count, input int limit);
        int target;
        int waited;
        target = range_cnt + count;
        waited = 0;
        while (range_cnt < target && waited < limit) begin
            cycle();
            waited++;
        end
        if (range_cnt < target) begin
            errors++;
            $display("timeout: range_stb did not arrive within %0d cycles", limit);
        end
    endtask

    // ####################################################################
    // test sequence
    // ####################################################################

    initial begin
        rst       = 1'b1;
        rx_serial = 1'b1;
        echo_stb  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        echo_mode = 1;
        repeat (2000) cycle();  // stray echoes with no run
        send_byte(8'($random(seed)), 1'b0);
        repeat (600) cycle();
        send_byte(8'($random(seed)), 1'b1);
        wait_ranges(3, 3 * RUN_CYCLES + 300);
        echo_mode = 2;
        wait_ranges(1, RUN_CYCLES + 300);
        echo_mode = 0;
        wait_ranges(1, RUN_CYCLES + 300);
        echo_mode = 1;
        repeat (1500) cycle();
        send_byte(8'($random(seed)), 1'b1);  // abort the run under way
        wait_ranges(1, RUN_CYCLES + 300);
        echo_mode = 3;
        wait_ranges(2, 2 * RUN_CYCLES + 300);
        $display("ranges seen: %0d, errors: %0d", range_cnt, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== echo_ranger.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_ranger (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rx_serial,
    input  logic                          echo_stb,
    output logic                          ping_stb,
    output logic [echo_pkg::RESULT_W-1:0] range,
    output logic                          range_stb,
    output logic                          frame_err
);

    logic                       start_stb;
    logic                       running;
    logic                       run_stb;
    logic [echo_pkg::WIN_W-1:0] window_time;
    logic [echo_pkg::WIN_W-1:0] first_time;
    logic [echo_pkg::WIN_W-1:0] last_time;
    logic                       hit;

    // ####################################################################
    // command and ping timing
    // ####################################################################

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .rx_serial (rx_serial),
        .start_stb (start_stb),
        .frame_err (frame_err)
    );

    ping_sequencer u_ping_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start_stb   (start_stb),
        .running     (running),
        .ping_stb    (ping_stb),
        .run_stb     (run_stb),
        .window_time (window_time)
    );

    // ####################################################################
    // echo timing and range
    // ####################################################################

    first_echo_timer u_first_echo_timer (
        .clk         (clk),
        .rst         (rst),
        .start_stb   (start_stb),
        .ping_stb    (ping_stb),
        .running     (running),
        .echo_stb    (echo_stb),
        .window_time (window_time),
        .first_time  (first_time),
        .hit         (hit)
    );

    last_echo_timer u_last_echo_timer (
        .clk         (clk),
        .rst         (rst),
        .start_stb   (start_stb),
        .ping_stb    (ping_stb),
        .running     (running),
        .echo_stb    (echo_stb),
        .window_time (window_time),
        .last_time   (last_time)
    );

    range_accumulator u_range_accumulator (
        .clk        (clk),
        .rst        (rst),
        .start_stb  (start_stb),
        .ping_stb   (ping_stb),
        .run_stb    (run_stb),
        .hit        (hit),
        .first_time (first_time),
        .last_time  (last_time),
        .range      (range),
        .range_stb  (range_stb)
    );

endmodule

`default_nettype wire

// ==== range_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module range_accumulator (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_stb,
    input  logic                          ping_stb,
    input  logic                          run_stb,
    input  logic                          hit,
    input  logic [echo_pkg::WIN_W-1:0]    first_time,
    input  logic [echo_pkg::WIN_W-1:0]    last_time,
    output logic [echo_pkg::RESULT_W-1:0] range,
    output logic                          range_stb
);

    logic [echo_pkg::SUM_W-1:0]    first_sum;
    logic [echo_pkg::SUM_W-1:0]    last_sum;
    logic [echo_pkg::SUM_W-1:0]    first_next;
    logic [echo_pkg::SUM_W-1:0]    last_next;
    logic [echo_pkg::RESULT_W-1:0] first_scaled;
    logic [echo_pkg::RESULT_W-1:0] last_scaled;

    // ####################################################################
    // fold of the window that closes at this ping
    // ####################################################################

    // at a ping the timers still show the window that just ended
    assign first_next = first_sum + (hit ? {{(echo_pkg::SUM_W - echo_pkg::WIN_W){1'b0}},
                                            first_time} : '0);
    assign last_next  = last_sum + (hit ? {{(echo_pkg::SUM_W - echo_pkg::WIN_W){1'b0}},
                                           last_time} : '0);

    assign first_scaled = {1'b0, first_next[echo_pkg::SUM_W-1:echo_pkg::SUM_SHIFT]};
    assign last_scaled  = {1'b0, last_next[echo_pkg::SUM_W-1:echo_pkg::SUM_SHIFT]};

    // ####################################################################
    // sums and result
    // ####################################################################

    always_ff @(posedge clk) begin
        if (rst || start_stb) begin
            first_sum <= '0;  // a run cut short by a new command is thrown away
            last_sum  <= '0;
            range_stb <= 1'b0;
        end else begin
            range_stb <= run_stb;
            if (run_stb) begin
                first_sum <= '0;
                last_sum  <= '0;
            end else if (ping_stb) begin
                first_sum <= first_next;
                last_sum  <= last_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run_stb) begin
            range <= first_scaled + last_scaled;
        end
    end

endmodule

`default_nettype wire

// ==== last_echo_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module last_echo_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_stb,
    input  logic                       ping_stb,
    input  logic                       running,
    input  logic                       echo_stb,
    input  logic [echo_pkg::WIN_W-1:0] window_time,
    output logic [echo_pkg::WIN_W-1:0] last_time
);

    logic accept;

    assign accept = echo_stb && running && !ping_stb && !start_stb;

    // whether the window saw any echo at all is tracked by the first echo timer
    always_ff @(posedge clk) begin
        if (rst || start_stb || ping_stb) begin
            last_time <= '0;
        end else if (accept) begin
            last_time <= window_time;  // each new echo replaces the one before
        end
    end

endmodule

`default_nettype wire

// ==== first_echo_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module first_echo_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_stb,
    input  logic                       ping_stb,
    input  logic                       running,
    input  logic                       echo_stb,
    input  logic [echo_pkg::WIN_W-1:0] window_time,
    output logic [echo_pkg::WIN_W-1:0] first_time,
    output logic                       hit
);

    logic accept;

    // an echo in the ping cycle belongs to no window
    assign accept = echo_stb && running && !ping_stb && !start_stb;

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (start_stb || ping_stb) begin
            hit <= 1'b0;
        end else if (accept) begin
            hit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_stb || ping_stb) begin
            first_time <= '0;
        end else if (accept && !hit) begin
            first_time <= window_time;  // later echoes in this window are dropped
        end
    end

endmodule

`default_nettype wire

// ==== ping_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ping_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_stb,
    output logic                       running,
    output logic                       ping_stb,
    output logic                       run_stb,
    output logic [echo_pkg::WIN_W-1:0] window_time
);

    logic [echo_pkg::RUN_W-1:0] run_cnt;
    logic                       first_run;

    // low bits count through one window, high bits count windows in a run
    assign window_time = run_cnt[echo_pkg::WIN_W-1:0];

    assign ping_stb = running && (window_time == '0);

    // the counter wraps to zero exactly once per run
    assign run_stb = ping_stb && (run_cnt == '0) && !first_run;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_cnt   <= '0;
            running   <= 1'b0;
            first_run <= 1'b0;
        end else if (start_stb) begin
            // a command in the middle of a run drops it and begins again
            run_cnt   <= '0;
            running   <= 1'b1;
            first_run <= 1'b1;
        end else if (running) begin
            run_cnt <= run_cnt + 1'b1;
            if (ping_stb) begin
                first_run <= 1'b0;  // from here on a wrap closes a finished run
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic clk,
    input  logic rst,
    input  logic rx_serial,
    output logic start_stb,
    output logic frame_err
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t                      state;
    logic [echo_pkg::BAUD_W-1:0] baud_cnt;
    logic [2:0]                  bit_idx;
    logic                        rx_prev;  // last line level, for the falling edge

    // the byte value itself carries no information, any byte is a start command
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            rx_prev   <= 1'b1;
            start_stb <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_prev   <= rx_serial;
            start_stb <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                IDLE: begin
                    if (rx_prev && !rx_serial) begin  // a held low line after a break is no edge
                        state    <= START;
                        baud_cnt <= '0;
                    end
                end
                START: begin
                    if (baud_cnt == echo_pkg::BAUD_HALF) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_serial ? IDLE : DATA;  // high here was only a glitch
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (baud_cnt == echo_pkg::BAUD_LAST) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (baud_cnt == echo_pkg::BAUD_LAST) begin
                        baud_cnt  <= '0;
                        start_stb <= rx_serial;
                        frame_err <= !rx_serial;
                        state     <= IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== echo_pkg.sv ====
`default_nettype none

package echo_pkg;

    // ####################################################################
    // serial command timing
    // ####################################################################

    localparam int CLKS_PER_BIT = 16;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);

    // sample points counted from the cycle after the edge that starts a bit
    localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);

    // ####################################################################
    // ping timing and datapath widths
    // ####################################################################

    localparam int PING_PERIOD   = 256;  // must be a power of two
    localparam int WIN_W         = $clog2(PING_PERIOD);
    localparam int PINGS_PER_RUN = 16;   // must be a power of two
    localparam int RUN_W         = $clog2(PING_PERIOD * PINGS_PER_RUN);

    // a full run of worst case times fits a sum without wrapping
    localparam int SUM_W     = WIN_W + $clog2(PINGS_PER_RUN);
    localparam int SUM_SHIFT = 4;

    // one extra bit holds the carry of the two scaled sums
    localparam int RESULT_W  = SUM_W - SUM_SHIFT + 1;

endpackage

`default_nettype wire
